// ==== ic_macros.svh ====
// Read interconnect parameters
`ifndef IC_MACROS_SVH
`define IC_MACROS_SVH

`define IC_ADDR_W 32
`define IC_DATA_W 32
`define IC_ID_W 4
`define IC_LEN_W 8

`define IC_N_MST 2
// Two slaves plus the decode-error target
`define IC_N_TGT 3
`define IC_MID_W 1
`define IC_TID_W 2

// Default address map
`define IC_S0_BASE 32'h0000_0000
`define IC_S0_LIMIT 32'h0000_FFFF
`define IC_S1_BASE 32'h0001_0000
`define IC_S1_LIMIT 32'h0001_FFFF

`endif

// ==== ic_pkg.sv ====
// Interconnect shared types
`default_nettype none
`include "ic_macros.svh"

package ic_pkg;

	typedef logic [`IC_ADDR_W-1:0] addr_t;
	typedef logic [`IC_ID_W-1:0] id_t;
	// Master tag sits above the original ID
	typedef logic [`IC_MID_W+`IC_ID_W-1:0] sid_t;
	typedef logic [`IC_LEN_W-1:0] len_t;
	typedef logic [`IC_DATA_W-1:0] data_t;
	typedef logic [1:0] resp_t;
	// 0 is slave 0, 1 is slave 1, 2 is the error target
	typedef logic [`IC_TID_W-1:0] tgt_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// ==== rr_arbiter.sv ====
// Round-robin arbiter
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
	parameter int N_REQ = 2,
	localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic [N_REQ-1:0] req_i,
	output logic gnt_o,
	output logic [IDX_W-1:0] gnt_id_o
);
	logic [N_REQ-1:0] masked;
	logic [N_REQ-1:0] pick;
	logic [IDX_W-1:0] next_id;

	// Requesters above the last grant win, else the lowest one
	always_comb begin
		for (int i = 0; i < N_REQ; i++) begin
			masked[i] = req_i[i] && (i > int'(gnt_id_o));
		end
		pick = (|masked) ? masked : req_i;
		next_id = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (pick[i]) begin
				next_id = IDX_W'(i);
			end
		end
	end

	// gnt_id_o keeps the last winner after the grant drops
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= 1'b0;
			gnt_id_o <= IDX_W'(N_REQ - 1);
		end else if (gnt_o) begin
			if (!req_i[gnt_id_o]) begin
				gnt_o <= 1'b0;
			end
		end else if (|req_i) begin
			gnt_o <= 1'b1;
			gnt_id_o <= next_id;
		end
	end

	// Waiting requesters stay raised until they win
	for (genvar i = 0; i < N_REQ; i++) begin : g_hold
		a_req_held: assert property (@(posedge clk) disable iff (!rstn)
			req_i[i] && !(gnt_o && gnt_id_o == IDX_W'(i)) |=> req_i[i]);
	end

endmodule

`default_nettype wire

// ==== ar_request_port.sv ====
// Read request capture and decode
`timescale 1ns/10ps
`default_nettype none
`include "ic_macros.svh"

module ar_request_port #(
	parameter int MST_IDX = 0,
	parameter ic_pkg::addr_t S0_BASE = `IC_S0_BASE,
	parameter ic_pkg::addr_t S0_LIMIT = `IC_S0_LIMIT,
	parameter ic_pkg::addr_t S1_BASE = `IC_S1_BASE,
	parameter ic_pkg::addr_t S1_LIMIT = `IC_S1_LIMIT
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic arvalid_i,
	input wire ic_pkg::addr_t araddr_i,
	input wire ic_pkg::id_t arid_i,
	input wire ic_pkg::len_t arlen_i,
	output logic arready_o,
	output logic [`IC_N_TGT-1:0] tgt_req_o,
	output ic_pkg::addr_t addr_o,
	output ic_pkg::sid_t sid_o,
	output ic_pkg::len_t len_o,
	input wire logic accept_i
);
	typedef enum logic [1:0] {P_IDLE, P_DECODE, P_ISSUE} pstate_e;
	localparam logic [`IC_MID_W-1:0] MST_TAG = `IC_MID_W'(MST_IDX);

	pstate_e state_q;
	ic_pkg::addr_t addr_q;
	ic_pkg::id_t id_q;
	ic_pkg::len_t len_q;
	ic_pkg::tgt_t tgt_q;
	ic_pkg::tgt_t dec_tgt;

	always_comb begin
		if (addr_q >= S0_BASE && addr_q <= S0_LIMIT) begin
			dec_tgt = ic_pkg::tgt_t'(0);
		end else if (addr_q >= S1_BASE && addr_q <= S1_LIMIT) begin
			dec_tgt = ic_pkg::tgt_t'(1);
		end else begin
			dec_tgt = ic_pkg::tgt_t'(2);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= P_IDLE;
		end else begin
			case (state_q)
				P_IDLE: begin
					if (arvalid_i) begin
						state_q <= P_DECODE;
					end
				end
				P_DECODE: state_q <= P_ISSUE;
				P_ISSUE: begin
					if (accept_i) begin
						state_q <= P_IDLE;
					end
				end
				default: state_q <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid_i && arready_o) begin
			addr_q <= araddr_i;
			id_q <= arid_i;
			len_q <= arlen_i;
		end
		if (state_q == P_DECODE) begin
			tgt_q <= dec_tgt;
		end
	end

	assign arready_o = (state_q == P_IDLE);
	assign tgt_req_o = (state_q == P_ISSUE) ? (`IC_N_TGT'(1) << tgt_q) : '0;
	assign addr_o = addr_q;
	// Tag lets the return path find this master
	assign sid_o = {MST_TAG, id_q};
	assign len_o = len_q;

	a_arvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid_i && !arready_o |=> arvalid_i);
	a_accept_issue: assert property (@(posedge clk) disable iff (!rstn)
		accept_i |-> state_q == P_ISSUE);

endmodule

`default_nettype wire

// ==== ar_target_mux.sv ====
// Per-target read address arbitration
`timescale 1ns/10ps
`default_nettype none
`include "ic_macros.svh"

module ar_target_mux (
	input wire logic clk,
	input wire logic rstn,
	input wire logic [`IC_N_MST-1:0] req_i,
	input wire ic_pkg::addr_t addr_i [`IC_N_MST],
	input wire ic_pkg::sid_t sid_i [`IC_N_MST],
	input wire ic_pkg::len_t len_i [`IC_N_MST],
	output logic arvalid_o,
	output ic_pkg::addr_t araddr_o,
	output ic_pkg::sid_t arid_o,
	output ic_pkg::len_t arlen_o,
	input wire logic arready_i,
	output logic [`IC_N_MST-1:0] accept_o
);
	logic gnt;
	logic [`IC_MID_W-1:0] gnt_id;

	rr_arbiter #(
		.N_REQ(`IC_N_MST)
	) u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(req_i),
		.gnt_o(gnt),
		.gnt_id_o(gnt_id)
	);

	// Request is gated so the cycle after accept shows no valid
	assign arvalid_o = gnt && req_i[gnt_id];
	assign araddr_o = gnt ? addr_i[gnt_id] : '0;
	assign arid_o = gnt ? sid_i[gnt_id] : '0;
	assign arlen_o = gnt ? len_i[gnt_id] : '0;

	always_comb begin
		accept_o = '0;
		accept_o[gnt_id] = arvalid_o && arready_i;
	end

endmodule

`default_nettype wire

// ==== r_return_router.sv ====
// Read data return router
`timescale 1ns/10ps
`default_nettype none
`include "ic_macros.svh"

module r_return_router (
	input wire logic clk,
	input wire logic rstn,
	input wire logic [`IC_N_TGT-1:0] t_rvalid_i,
	input wire ic_pkg::data_t t_rdata_i [`IC_N_TGT],
	input wire ic_pkg::resp_t t_rresp_i [`IC_N_TGT],
	input wire ic_pkg::sid_t t_rid_i [`IC_N_TGT],
	input wire logic [`IC_N_TGT-1:0] t_rlast_i,
	output logic [`IC_N_TGT-1:0] t_rready_o,
	output logic [`IC_N_MST-1:0] m_rvalid_o,
	output ic_pkg::data_t m_rdata_o [`IC_N_MST],
	output ic_pkg::resp_t m_rresp_o [`IC_N_MST],
	output ic_pkg::id_t m_rid_o [`IC_N_MST],
	output logic [`IC_N_MST-1:0] m_rlast_o,
	input wire logic [`IC_N_MST-1:0] m_rready_i
);
	typedef enum logic [1:0] {R_IDLE, R_REQ, R_CONN} rstate_e;

	rstate_e state_q [`IC_N_TGT];
	logic [`IC_MID_W-1:0] mst_q [`IC_N_TGT];
	logic [`IC_N_TGT-1:0] r_req [`IC_N_MST];
	logic m_gnt [`IC_N_MST];
	ic_pkg::tgt_t m_gnt_id [`IC_N_MST];
	logic [`IC_N_MST-1:0] m_conn;

	for (genvar t = 0; t < `IC_N_TGT; t++) begin : g_tgt
		always_ff @(posedge clk) begin
			if (!rstn) begin
				state_q[t] <= R_IDLE;
			end else begin
				case (state_q[t])
					R_IDLE: begin
						if (t_rvalid_i[t]) begin
							state_q[t] <= R_REQ;
						end
					end
					R_REQ: begin
						if (m_gnt[mst_q[t]] && m_gnt_id[mst_q[t]] == t) begin
							state_q[t] <= R_CONN;
						end
					end
					R_CONN: begin
						if (t_rvalid_i[t] && t_rready_o[t] && t_rlast_i[t]) begin
							state_q[t] <= R_IDLE;
						end
					end
					default: state_q[t] <= R_IDLE;
				endcase
			end
		end

		// Tag is sampled while idle so it is ready with the first beat
		always_ff @(posedge clk) begin
			if (state_q[t] == R_IDLE) begin
				mst_q[t] <= t_rid_i[t][`IC_ID_W +: `IC_MID_W];
			end
		end

		a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
			t_rvalid_i[t] && !t_rready_o[t] |=> t_rvalid_i[t]);
	end

	for (genvar m = 0; m < `IC_N_MST; m++) begin : g_mst
		rr_arbiter #(
			.N_REQ(`IC_N_TGT)
		) u_arb (
			.clk(clk),
			.rstn(rstn),
			.req_i(r_req[m]),
			.gnt_o(m_gnt[m]),
			.gnt_id_o(m_gnt_id[m])
		);
	end

	always_comb begin
		for (int t = 0; t < `IC_N_TGT; t++) begin
			t_rready_o[t] = (state_q[t] == R_CONN) && m_rready_i[mst_q[t]];
			for (int m = 0; m < `IC_N_MST; m++) begin
				r_req[m][t] = (state_q[t] != R_IDLE) && (mst_q[t] == m);
			end
		end
	end

	// Only a connected target reaches its master
	always_comb begin
		for (int m = 0; m < `IC_N_MST; m++) begin
			m_conn[m] = m_gnt[m] && (state_q[m_gnt_id[m]] == R_CONN);
			m_rvalid_o[m] = m_conn[m] && t_rvalid_i[m_gnt_id[m]];
			m_rlast_o[m] = m_conn[m] && t_rlast_i[m_gnt_id[m]];
			m_rdata_o[m] = m_conn[m] ? t_rdata_i[m_gnt_id[m]] : '0;
			m_rresp_o[m] = m_conn[m] ? t_rresp_i[m_gnt_id[m]] : '0;
			m_rid_o[m] = m_conn[m] ? t_rid_i[m_gnt_id[m]][`IC_ID_W-1:0] : '0;
		end
	end

endmodule

`default_nettype wire

// ==== decerr_target.sv ====
// Decode-error read target
`timescale 1ns/10ps
`default_nettype none

module decerr_target (
	input wire logic clk,
	input wire logic rstn,
	input wire logic arvalid_i,
	input wire ic_pkg::sid_t arid_i,
	input wire ic_pkg::len_t arlen_i,
	output logic arready_o,
	output logic rvalid_o,
	output ic_pkg::data_t rdata_o,
	output ic_pkg::resp_t rresp_o,
	output ic_pkg::sid_t rid_o,
	output logic rlast_o,
	input wire logic rready_i
);
	logic busy_q;
	ic_pkg::sid_t id_q;
	ic_pkg::len_t len_q;
	ic_pkg::len_t cnt_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
		end else if (!busy_q) begin
			if (arvalid_i) begin
				busy_q <= 1'b1;
				cnt_q <= '0;
			end
		end else if (rready_i) begin
			if (rlast_o) begin
				busy_q <= 1'b0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid_i && arready_o) begin
			id_q <= arid_i;
			len_q <= arlen_i;
		end
	end

	assign arready_o = !busy_q;
	assign rvalid_o = busy_q;
	assign rdata_o = '0;
	assign rresp_o = ic_pkg::RESP_DECERR;
	assign rid_o = busy_q ? id_q : '0;
	assign rlast_o = busy_q && (cnt_q == len_q);

	a_arvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid_i && !arready_o |=> arvalid_i && $stable(arlen_i));

endmodule

`default_nettype wire

// ==== axi_read_xbar_2x2.sv ====
// Two by two AXI read crossbar
`timescale 1ns/10ps
`default_nettype none
`include "ic_macros.svh"

module axi_read_xbar_2x2 #(
	parameter ic_pkg::addr_t S0_BASE = `IC_S0_BASE,
	parameter ic_pkg::addr_t S0_LIMIT = `IC_S0_LIMIT,
	parameter ic_pkg::addr_t S1_BASE = `IC_S1_BASE,
	parameter ic_pkg::addr_t S1_LIMIT = `IC_S1_LIMIT
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic m0_arvalid_i,
	input wire ic_pkg::addr_t m0_araddr_i,
	input wire ic_pkg::id_t m0_arid_i,
	input wire ic_pkg::len_t m0_arlen_i,
	output logic m0_arready_o,
	output logic m0_rvalid_o,
	output ic_pkg::data_t m0_rdata_o,
	output ic_pkg::resp_t m0_rresp_o,
	output ic_pkg::id_t m0_rid_o,
	output logic m0_rlast_o,
	input wire logic m0_rready_i,
	input wire logic m1_arvalid_i,
	input wire ic_pkg::addr_t m1_araddr_i,
	input wire ic_pkg::id_t m1_arid_i,
	input wire ic_pkg::len_t m1_arlen_i,
	output logic m1_arready_o,
	output logic m1_rvalid_o,
	output ic_pkg::data_t m1_rdata_o,
	output ic_pkg::resp_t m1_rresp_o,
	output ic_pkg::id_t m1_rid_o,
	output logic m1_rlast_o,
	input wire logic m1_rready_i,
	output logic s0_arvalid_o,
	output ic_pkg::addr_t s0_araddr_o,
	output ic_pkg::sid_t s0_arid_o,
	output ic_pkg::len_t s0_arlen_o,
	input wire logic s0_arready_i,
	input wire logic s0_rvalid_i,
	input wire ic_pkg::data_t s0_rdata_i,
	input wire ic_pkg::resp_t s0_rresp_i,
	input wire ic_pkg::sid_t s0_rid_i,
	input wire logic s0_rlast_i,
	output logic s0_rready_o,
	output logic s1_arvalid_o,
	output ic_pkg::addr_t s1_araddr_o,
	output ic_pkg::sid_t s1_arid_o,
	output ic_pkg::len_t s1_arlen_o,
	input wire logic s1_arready_i,
	input wire logic s1_rvalid_i,
	input wire ic_pkg::data_t s1_rdata_i,
	input wire ic_pkg::resp_t s1_rresp_i,
	input wire ic_pkg::sid_t s1_rid_i,
	input wire logic s1_rlast_i,
	output logic s1_rready_o
);
	wire [`IC_N_TGT-1:0] req_tgt [`IC_N_MST];
	wire ic_pkg::addr_t req_addr [`IC_N_MST];
	wire ic_pkg::sid_t req_sid [`IC_N_MST];
	wire ic_pkg::len_t req_len [`IC_N_MST];
	wire [`IC_N_MST-1:0] t_accept [`IC_N_TGT];
	logic [`IC_N_MST-1:0] m_accept;
	wire [`IC_N_TGT-1:0] t_arvalid;
	wire ic_pkg::addr_t t_araddr [`IC_N_TGT];
	wire ic_pkg::sid_t t_arid [`IC_N_TGT];
	wire ic_pkg::len_t t_arlen [`IC_N_TGT];
	wire [`IC_N_TGT-1:0] t_arready;
	wire [`IC_N_TGT-1:0] t_rvalid;
	wire [`IC_N_TGT-1:0] t_rlast;
	wire [`IC_N_TGT-1:0] t_rready;
	wire ic_pkg::data_t t_rdata [`IC_N_TGT];
	wire ic_pkg::resp_t t_rresp [`IC_N_TGT];
	wire ic_pkg::sid_t t_rid [`IC_N_TGT];
	wire [`IC_N_MST-1:0] m_rvalid;
	wire [`IC_N_MST-1:0] m_rlast;
	wire ic_pkg::data_t m_rdata [`IC_N_MST];
	wire ic_pkg::resp_t m_rresp [`IC_N_MST];
	wire ic_pkg::id_t m_rid [`IC_N_MST];

	ar_request_port #(
		.MST_IDX(0),
		.S0_BASE(S0_BASE),
		.S0_LIMIT(S0_LIMIT),
		.S1_BASE(S1_BASE),
		.S1_LIMIT(S1_LIMIT)
	) u_req0 (
		.clk(clk),
		.rstn(rstn),
		.arvalid_i(m0_arvalid_i),
		.araddr_i(m0_araddr_i),
		.arid_i(m0_arid_i),
		.arlen_i(m0_arlen_i),
		.arready_o(m0_arready_o),
		.tgt_req_o(req_tgt[0]),
		.addr_o(req_addr[0]),
		.sid_o(req_sid[0]),
		.len_o(req_len[0]),
		.accept_i(m_accept[0])
	);

	ar_request_port #(
		.MST_IDX(1),
		.S0_BASE(S0_BASE),
		.S0_LIMIT(S0_LIMIT),
		.S1_BASE(S1_BASE),
		.S1_LIMIT(S1_LIMIT)
	) u_req1 (
		.clk(clk),
		.rstn(rstn),
		.arvalid_i(m1_arvalid_i),
		.araddr_i(m1_araddr_i),
		.arid_i(m1_arid_i),
		.arlen_i(m1_arlen_i),
		.arready_o(m1_arready_o),
		.tgt_req_o(req_tgt[1]),
		.addr_o(req_addr[1]),
		.sid_o(req_sid[1]),
		.len_o(req_len[1]),
		.accept_i(m_accept[1])
	);

	for (genvar t = 0; t < `IC_N_TGT; t++) begin : g_ar
		ar_target_mux u_mux (
			.clk(clk),
			.rstn(rstn),
			.req_i({req_tgt[1][t], req_tgt[0][t]}),
			.addr_i(req_addr),
			.sid_i(req_sid),
			.len_i(req_len),
			.arvalid_o(t_arvalid[t]),
			.araddr_o(t_araddr[t]),
			.arid_o(t_arid[t]),
			.arlen_o(t_arlen[t]),
			.arready_i(t_arready[t]),
			.accept_o(t_accept[t])
		);
	end

	// A master is accepted by whichever target it asked
	always_comb begin
		m_accept = '0;
		for (int t = 0; t < `IC_N_TGT; t++) begin
			m_accept = m_accept | t_accept[t];
		end
	end

	decerr_target u_decerr (
		.clk(clk),
		.rstn(rstn),
		.arvalid_i(t_arvalid[2]),
		.arid_i(t_arid[2]),
		.arlen_i(t_arlen[2]),
		.arready_o(t_arready[2]),
		.rvalid_o(t_rvalid[2]),
		.rdata_o(t_rdata[2]),
		.rresp_o(t_rresp[2]),
		.rid_o(t_rid[2]),
		.rlast_o(t_rlast[2]),
		.rready_i(t_rready[2])
	);

	r_return_router u_router (
		.clk(clk),
		.rstn(rstn),
		.t_rvalid_i(t_rvalid),
		.t_rdata_i(t_rdata),
		.t_rresp_i(t_rresp),
		.t_rid_i(t_rid),
		.t_rlast_i(t_rlast),
		.t_rready_o(t_rready),
		.m_rvalid_o(m_rvalid),
		.m_rdata_o(m_rdata),
		.m_rresp_o(m_rresp),
		.m_rid_o(m_rid),
		.m_rlast_o(m_rlast),
		.m_rready_i({m1_rready_i, m0_rready_i})
	);

	assign t_arready[1:0] = {s1_arready_i, s0_arready_i};
	assign t_rvalid[1:0] = {s1_rvalid_i, s0_rvalid_i};
	assign t_rlast[1:0] = {s1_rlast_i, s0_rlast_i};
	assign t_rdata[0] = s0_rdata_i;
	assign t_rdata[1] = s1_rdata_i;
	assign t_rresp[0] = s0_rresp_i;
	assign t_rresp[1] = s1_rresp_i;
	assign t_rid[0] = s0_rid_i;
	assign t_rid[1] = s1_rid_i;

	assign s0_arvalid_o = t_arvalid[0];
	assign s0_araddr_o = t_araddr[0];
	assign s0_arid_o = t_arid[0];
	assign s0_arlen_o = t_arlen[0];
	assign s0_rready_o = t_rready[0];
	assign s1_arvalid_o = t_arvalid[1];
	assign s1_araddr_o = t_araddr[1];
	assign s1_arid_o = t_arid[1];
	assign s1_arlen_o = t_arlen[1];
	assign s1_rready_o = t_rready[1];

	assign m0_rvalid_o = m_rvalid[0];
	assign m0_rdata_o = m_rdata[0];
	assign m0_rresp_o = m_rresp[0];
	assign m0_rid_o = m_rid[0];
	assign m0_rlast_o = m_rlast[0];
	assign m1_rvalid_o = m_rvalid[1];
	assign m1_rdata_o = m_rdata[1];
	assign m1_rresp_o = m_rresp[1];
	assign m1_rid_o = m_rid[1];
	assign m1_rlast_o = m_rlast[1];

endmodule

`default_nettype wire

// ==== tb_slave_model.sv ====
// AXI read slave model
`timescale 1ns/10ps
`default_nettype none

module tb_slave_model #(
	parameter int IDX = 0,
	parameter int SEED = 1
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic arvalid_i,
	input wire ic_pkg::addr_t araddr_i,
	input wire ic_pkg::sid_t arid_i,
	input wire ic_pkg::len_t arlen_i,
	output logic arready_o,
	output logic rvalid_o,
	output ic_pkg::data_t rdata_o,
	output ic_pkg::resp_t rresp_o,
	output ic_pkg::sid_t rid_o,
	output logic rlast_o,
	input wire logic rready_i
);
	integer seed = SEED;
	logic busy;
	logic beat_done;
	ic_pkg::addr_t addr_q;
	ic_pkg::sid_t sid_q;
	ic_pkg::len_t len_q;
	ic_pkg::len_t beat_q;
	ic_pkg::addr_t beat_addr;

	initial begin
		arready_o = 1'b0;
		rvalid_o = 1'b0;
		rdata_o = '0;
		rresp_o = ic_pkg::RESP_OKAY;
		rid_o = '0;
		rlast_o = 1'b0;
	end

	// Handshakes are taken on the rising edge
	always @(posedge clk) begin
		beat_done <= rvalid_o && rready_i;
		if (!rstn) begin
			busy <= 1'b0;
			addr_q <= '0;
			sid_q <= '0;
			len_q <= '0;
			beat_q <= '0;
		end else if (!busy && arvalid_i && arready_o) begin
			busy <= 1'b1;
			addr_q <= araddr_i;
			sid_q <= arid_i;
			len_q <= arlen_i;
			beat_q <= '0;
		end else if (busy && rvalid_o && rready_i) begin
			if (rlast_o) begin
				busy <= 1'b0;
			end else begin
				beat_q <= beat_q + 1'b1;
			end
		end
	end

	// A raised rvalid waits for its handshake before it may drop
	always @(negedge clk) begin
		if (!rstn) begin
			arready_o = 1'b0;
			rvalid_o = 1'b0;
			rlast_o = 1'b0;
		end else begin
			arready_o = !busy && (($random(seed) & 3) != 0);
			if (!rvalid_o || beat_done) begin
				rvalid_o = busy && (($random(seed) & 3) != 0);
			end
			beat_addr = addr_q + ic_pkg::addr_t'(4 * int'(beat_q));
			rdata_o = {8'(IDX), beat_addr[23:0]};
			rresp_o = ic_pkg::RESP_OKAY;
			rid_o = sid_q;
			rlast_o = busy && (beat_q == len_q);
		end
	end

endmodule

`default_nettype wire

// ==== tb_axi_read_xbar.sv ====
// Read crossbar testbench
`timescale 1ns/10ps
`default_nettype none
`include "ic_macros.svh"

module tb_axi_read_xbar;
	localparam int MAX_BEATS = 8;
	localparam int N_CONTEND = 10;
	localparam int N_STRESS = 20;
	localparam int N_TXN = 4 + `IC_N_MST * (N_CONTEND + N_STRESS);
	localparam int WATCHDOG_CYCLES = N_TXN * MAX_BEATS * 40;
	localparam ic_pkg::addr_t UNMAPPED_BASE = 32'h0004_0000;
	localparam int N_ID = 2 ** `IC_ID_W;

	logic clk;
	logic rstn;
	integer seed;
	integer rdy_seed;
	int errors;
	int pending;
	logic rready_random;
	string test_name;

	logic m_arvalid [`IC_N_MST];
	ic_pkg::addr_t m_araddr [`IC_N_MST];
	ic_pkg::id_t m_arid [`IC_N_MST];
	ic_pkg::len_t m_arlen [`IC_N_MST];
	logic m_rready [`IC_N_MST];
	wire m_arready [`IC_N_MST];
	wire m_rvalid [`IC_N_MST];
	wire ic_pkg::data_t m_rdata [`IC_N_MST];
	wire ic_pkg::resp_t m_rresp [`IC_N_MST];
	wire ic_pkg::id_t m_rid [`IC_N_MST];
	wire m_rlast [`IC_N_MST];

	wire s_arvalid [2];
	wire ic_pkg::addr_t s_araddr [2];
	wire ic_pkg::sid_t s_arid [2];
	wire ic_pkg::len_t s_arlen [2];
	wire s_arready [2];
	wire s_rvalid [2];
	wire ic_pkg::data_t s_rdata [2];
	wire ic_pkg::resp_t s_rresp [2];
	wire ic_pkg::sid_t s_rid [2];
	wire s_rlast [2];
	wire s_rready [2];

	// Expected beats per master and ID
	ic_pkg::data_t exp_data [`IC_N_MST][N_ID][$];
	ic_pkg::resp_t exp_resp [`IC_N_MST][N_ID][$];
	logic exp_last [`IC_N_MST][N_ID][$];
	// Each target serves one burst at a time, so its IDs return in issue order
	ic_pkg::id_t id_order [`IC_N_MST][`IC_N_TGT][$];
	ic_pkg::id_t next_id [`IC_N_MST];
	logic in_burst [`IC_N_MST];
	ic_pkg::id_t cur_id [`IC_N_MST];

	ic_pkg::addr_t rnd_addr [`IC_N_MST][$];
	ic_pkg::len_t rnd_len [`IC_N_MST][$];
	int rnd_gap [`IC_N_MST][$];

	axi_read_xbar_2x2 u_axi_read_xbar_2x2 (
		.clk(clk),
		.rstn(rstn),
		.m0_arvalid_i(m_arvalid[0]),
		.m0_araddr_i(m_araddr[0]),
		.m0_arid_i(m_arid[0]),
		.m0_arlen_i(m_arlen[0]),
		.m0_arready_o(m_arready[0]),
		.m0_rvalid_o(m_rvalid[0]),
		.m0_rdata_o(m_rdata[0]),
		.m0_rresp_o(m_rresp[0]),
		.m0_rid_o(m_rid[0]),
		.m0_rlast_o(m_rlast[0]),
		.m0_rready_i(m_rready[0]),
		.m1_arvalid_i(m_arvalid[1]),
		.m1_araddr_i(m_araddr[1]),
		.m1_arid_i(m_arid[1]),
		.m1_arlen_i(m_arlen[1]),
		.m1_arready_o(m_arready[1]),
		.m1_rvalid_o(m_rvalid[1]),
		.m1_rdata_o(m_rdata[1]),
		.m1_rresp_o(m_rresp[1]),
		.m1_rid_o(m_rid[1]),
		.m1_rlast_o(m_rlast[1]),
		.m1_rready_i(m_rready[1]),
		.s0_arvalid_o(s_arvalid[0]),
		.s0_araddr_o(s_araddr[0]),
		.s0_arid_o(s_arid[0]),
		.s0_arlen_o(s_arlen[0]),
		.s0_arready_i(s_arready[0]),
		.s0_rvalid_i(s_rvalid[0]),
		.s0_rdata_i(s_rdata[0]),
		.s0_rresp_i(s_rresp[0]),
		.s0_rid_i(s_rid[0]),
		.s0_rlast_i(s_rlast[0]),
		.s0_rready_o(s_rready[0]),
		.s1_arvalid_o(s_arvalid[1]),
		.s1_araddr_o(s_araddr[1]),
		.s1_arid_o(s_arid[1]),
		.s1_arlen_o(s_arlen[1]),
		.s1_arready_i(s_arready[1]),
		.s1_rvalid_i(s_rvalid[1]),
		.s1_rdata_i(s_rdata[1]),
		.s1_rresp_i(s_rresp[1]),
		.s1_rid_i(s_rid[1]),
		.s1_rlast_i(s_rlast[1]),
		.s1_rready_o(s_rready[1])
	);

	for (genvar s = 0; s < 2; s++) begin : g_slv
		tb_slave_model #(
			.IDX(s),
			.SEED(43565 + 2 + s)
		) u_slv (
			.clk(clk),
			.rstn(rstn),
			.arvalid_i(s_arvalid[s]),
			.araddr_i(s_araddr[s]),
			.arid_i(s_arid[s]),
			.arlen_i(s_arlen[s]),
			.arready_o(s_arready[s]),
			.rvalid_o(s_rvalid[s]),
			.rdata_o(s_rdata[s]),
			.rresp_o(s_rresp[s]),
			.rid_o(s_rid[s]),
			.rlast_o(s_rlast[s]),
			.rready_i(s_rready[s])
		);
	end

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic abort_run();
		errors++;
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_data(input string what, input ic_pkg::data_t exp,
		input ic_pkg::data_t act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_resp(input string what, input ic_pkg::resp_t exp,
		input ic_pkg::resp_t act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_id(input string what, input ic_pkg::id_t exp, input ic_pkg::id_t act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	function automatic int target_of(input ic_pkg::addr_t a);
		if (a >= `IC_S0_BASE && a <= `IC_S0_LIMIT) begin
			return 0;
		end
		if (a >= `IC_S1_BASE && a <= `IC_S1_LIMIT) begin
			return 1;
		end
		return 2;
	endfunction

	// Slave beat n carries the start address plus 4n under the slave index
	function automatic ic_pkg::data_t slave_beat(input int idx, input ic_pkg::addr_t a,
		input int n);
		ic_pkg::addr_t beat_addr;
		beat_addr = a + ic_pkg::addr_t'(4 * n);
		return {8'(idx), beat_addr[23:0]};
	endfunction

	task automatic expect_read(input int m, input ic_pkg::addr_t a, input ic_pkg::id_t id,
		input ic_pkg::len_t len);
		int t;
		t = target_of(a);
		id_order[m][t].push_back(id);
		for (int n = 0; n <= int'(len); n++) begin
			if (t == 2) begin
				exp_data[m][id].push_back('0);
				exp_resp[m][id].push_back(ic_pkg::RESP_DECERR);
			end else begin
				exp_data[m][id].push_back(slave_beat(t, a, n));
				exp_resp[m][id].push_back(ic_pkg::RESP_OKAY);
			end
			exp_last[m][id].push_back(n == int'(len));
		end
		pending += int'(len) + 1;
	endtask

	task automatic issue_read(input int m, input ic_pkg::addr_t a, input ic_pkg::len_t len);
		ic_pkg::id_t id;
		logic accepted;
		id = next_id[m];
		next_id[m] = id + 1'b1;
		expect_read(m, a, id, len);
		@(negedge clk);
		m_arvalid[m] = 1'b1;
		m_araddr[m] = a;
		m_arid[m] = id;
		m_arlen[m] = len;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = m_arready[m];
		end
		@(negedge clk);
		m_arvalid[m] = 1'b0;
	endtask

	task automatic make_random(input int count, input logic any_target);
		int sel;
		ic_pkg::addr_t off;
		for (int i = 0; i < count; i++) begin
			for (int m = 0; m < `IC_N_MST; m++) begin
				sel = any_target ? int'($unsigned($random(seed)) % 3) : 0;
				off = ic_pkg::addr_t'($random(seed)) & 32'h0000_FFFC;
				case (sel)
					0: rnd_addr[m].push_back(`IC_S0_BASE + off);
					1: rnd_addr[m].push_back(`IC_S1_BASE + off);
					default: rnd_addr[m].push_back(UNMAPPED_BASE + off);
				endcase
				rnd_len[m].push_back(ic_pkg::len_t'($unsigned($random(seed)) % MAX_BEATS));
				rnd_gap[m].push_back(int'($unsigned($random(seed)) % 4));
			end
		end
	endtask

	task automatic issue_stream(input int m);
		while (rnd_addr[m].size() > 0) begin
			repeat (rnd_gap[m].pop_front()) @(negedge clk);
			issue_read(m, rnd_addr[m].pop_front(), rnd_len[m].pop_front());
		end
	endtask

	task automatic run_random();
		fork
			issue_stream(0);
			issue_stream(1);
		join
	endtask

	task automatic wait_idle();
		while (pending != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic check_beat(input int m);
		ic_pkg::id_t id;
		int t;
		// A first beat names its source by its response and top data byte
		if (m_rresp[m] == ic_pkg::RESP_DECERR) begin
			t = 2;
		end else begin
			t = int'(m_rdata[m][`IC_DATA_W-1 -: 8]);
		end
		if (!in_burst[m] && (t >= `IC_N_TGT || id_order[m][t].size() == 0)) begin
			$display("Master %0d got a burst from target %0d that was never requested",
				m, t);
			abort_run();
		end else begin
			if (!in_burst[m]) begin
				cur_id[m] = id_order[m][t].pop_front();
				in_burst[m] = 1'b1;
			end
			id = cur_id[m];
			if (exp_data[m][id].size() == 0) begin
				$display("Master %0d received more beats for ID %0h than were requested",
					m, id);
				abort_run();
			end else begin
				check_id($sformatf("m%0d rid", m), id, m_rid[m]);
				check_data($sformatf("m%0d rdata", m), exp_data[m][id].pop_front(),
					m_rdata[m]);
				check_resp($sformatf("m%0d rresp", m), exp_resp[m][id].pop_front(),
					m_rresp[m]);
				check_bit($sformatf("m%0d rlast", m), exp_last[m][id].pop_front(),
					m_rlast[m]);
				if (m_rlast[m]) begin
					in_burst[m] = 1'b0;
				end
				pending--;
			end
		end
	endtask

	// Beat monitor at each master
	always @(posedge clk) begin
		for (int m = 0; m < `IC_N_MST; m++) begin
			if (rstn && m_rvalid[m] && m_rready[m]) begin
				check_beat(m);
			end
		end
	end

	always @(negedge clk) begin
		for (int m = 0; m < `IC_N_MST; m++) begin
			m_rready[m] = rready_random ? (($random(rdy_seed) & 3) != 0) : 1'b1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		seed = 43565;
		rdy_seed = seed + 1;
		errors = 0;
		pending = 0;
		rready_random = 1'b0;
		rstn = 1'b0;
		for (int m = 0; m < `IC_N_MST; m++) begin
			m_arvalid[m] = 1'b0;
			m_araddr[m] = '0;
			m_arid[m] = '0;
			m_arlen[m] = '0;
			m_rready[m] = 1'b0;
			next_id[m] = '0;
			in_burst[m] = 1'b0;
			cur_id[m] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);

		test_name = "reset";
		check_bit("s0 arvalid", 1'b0, s_arvalid[0]);
		check_bit("s1 arvalid", 1'b0, s_arvalid[1]);
		check_bit("s0 rready", 1'b0, s_rready[0]);
		check_bit("s1 rready", 1'b0, s_rready[1]);
		for (int m = 0; m < `IC_N_MST; m++) begin
			check_bit($sformatf("m%0d rvalid", m), 1'b0, m_rvalid[m]);
			check_bit($sformatf("m%0d arready", m), 1'b1, m_arready[m]);
		end
		rstn = 1'b1;

		test_name = "single_s0";
		issue_read(0, 32'h0000_0100, 8'd3);
		wait_idle();
		issue_read(1, 32'h0000_2200, 8'd7);
		wait_idle();

		test_name = "single_s1";
		issue_read(0, 32'h0001_0040, 8'd5);
		wait_idle();

		test_name = "unmapped";
		issue_read(1, UNMAPPED_BASE, 8'd2);
		wait_idle();

		test_name = "contention_s0";
		make_random(N_CONTEND, 1'b0);
		run_random();
		wait_idle();

		test_name = "backpressure";
		rready_random = 1'b1;
		make_random(N_STRESS, 1'b1);
		run_random();
		wait_idle();

		if (errors == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
ic_pkg.sv
rr_arbiter.sv
ar_request_port.sv
ar_target_mux.sv
r_return_router.sv
decerr_target.sv
axi_read_xbar_2x2.sv
tb_slave_model.sv
tb_axi_read_xbar.sv

// ==== Bender.yml ====
package:
  name: axi_read_xbar_2x2

export_include_dirs:
  - .

sources:
  - ic_pkg.sv
  - rr_arbiter.sv
  - ar_request_port.sv
  - ar_target_mux.sv
  - r_return_router.sv
  - decerr_target.sv
  - axi_read_xbar_2x2.sv
  - target: test
    files:
      - tb_slave_model.sv
      - tb_axi_read_xbar.sv
